/* flist.f */
+incdir+test
source/hmc_lane_pkg.sv
source/lane_permute.sv
source/link_reset_seq.sv
source/hmc_phy_bridge.sv
test/tb_hmc_phy_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator, once per mezzanine site

cd "$(dirname "$0")" || exit 1

result=0

for site in 2 3; do
  build_dir="build_site${site}"
  log_file="sim_site${site}.log"

  echo "Building for mezzanine site ${site}"
  verilator --binary -Wno-fatal -f flist.f --top-module tb_hmc_phy_bridge \
    -Glink_site=${site} -Mdir "${build_dir}" -o sim_tb
  if [ $? -ne 0 ]; then
    echo "Verilator build failed for site ${site}"
    exit 1
  fi

  "./${build_dir}/sim_tb" > "${log_file}" 2>&1
  if [ $? -ne 0 ]; then
    echo "Simulation exited with an error for site ${site}"
    result=1
  fi

  if grep -q "TEST FAILED" "${log_file}"; then
    echo "Site ${site} failed, see ${log_file}"
    result=1
  else
    echo "Site ${site} passed"
  fi
done

exit ${result}

/* test/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------
// Helpers
// --------------------

task automatic compare_value(input string name, input logic [link_width-1:0] expected,
                             input logic [link_width-1:0] actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("mismatch %s: expected %0h actual %0h", name, expected, actual);
  end
endtask

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;   // Numerical Recipes constants
  return lcg_state;
endfunction

function automatic link_word_t random_link_word();
  link_word_t  w;
  logic [31:0] hi;
  logic [31:0] lo;
  for (int k = 0; k < num_lanes; k++) begin
    hi   = lcg_next();
    lo   = lcg_next();
    w[k] = {hi, lo};
  end
  return w;
endfunction

// Link lane i lands on channel site_map[i]
function automatic link_word_t scatter_lanes(input link_word_t w);
  link_word_t r;
  for (int i = 0; i < num_lanes; i++) r[site_map[i]] = w[i];
  return r;
endfunction

// Channel site_map[i] returns to link lane i
function automatic link_word_t gather_lanes(input link_word_t w);
  link_word_t r;
  for (int i = 0; i < num_lanes; i++) r[i] = w[site_map[i]];
  return r;
endfunction

// --------------------
// Directed tests
// --------------------

task automatic check_reset_release();
  int locked_cycles;
  bit released;
  @(negedge clk_hmc);   // Inside the two reset cycles
  compare_value("reset_hold_hmc_reset", 1, status.hmc_reset);
  compare_value("reset_hold_hmc_res_n", 0, hmc_res_n);
  compare_value("reset_hold_tx_soft_reset", 1, gt_tx_soft_reset);
  compare_value("reset_hold_rx_soft_reset", 1, gt_rx_soft_reset);
  compare_value("reset_hold_gt_tx_data", 0, gt_tx_data);
  compare_value("reset_hold_link_rx_data", 0, link_rx_data);
  compare_value("reset_hold_gt_rx_slide", 0, gt_rx_slide);
  @(posedge clk_hmc);
  SOFT_RESET_IN <= 1'b0;   // Released after the second edge
  link_tx_data  <= '0;
  gt_rx_data    <= '0;
  link_bit_slip <= '0;
  @(negedge clk_hmc);
  compare_value("after_reset_gt_tx_data", 0, gt_tx_data);
  compare_value("after_reset_link_rx_data", 0, link_rx_data);
  compare_value("after_reset_gt_rx_slide", 0, gt_rx_slide);
  repeat (100) begin   // Count must hold while unlocked
    @(negedge clk_hmc);
    compare_value("unlocked_hmc_reset", 1, status.hmc_reset);
  end
  @(posedge clk_hmc);
  gt_status.mmcm_locked <= 1'b1;
  locked_cycles = 0;
  released      = 1'b0;
  while (!released && locked_cycles < lock_limit) begin
    @(posedge clk_hmc);
    locked_cycles++;
    @(negedge clk_hmc);
    if (!status.hmc_reset) released = 1'b1;
  end
  if (!released) begin
    errors++;
    $display("error: controller reset still held after %0d locked cycles", locked_cycles);
  end else begin
    compare_value("reset_release_cycles", 1 << reset_count_log2, locked_cycles);
    compare_value("reset_release_hmc_res_n", 1, hmc_res_n);
  end
endtask

task automatic route_tx_stream();
  link_word_t sent[$];
  link_word_t word;
  for (int i = 0; i <= 32; i++) begin
    @(posedge clk_hmc);
    word = (i < 32) ? random_link_word() : '0;
    link_tx_data <= word;
    if (i < 32) sent.push_back(word);
    @(negedge clk_hmc);
    if (i > 0) compare_value("tx_routing", scatter_lanes(sent.pop_front()), gt_tx_data);
  end
endtask

task automatic route_rx_stream();
  link_word_t sent[$];
  link_word_t word;
  for (int i = 0; i <= 32; i++) begin
    @(posedge clk_hmc);
    word = (i < 32) ? random_link_word() : '0;
    gt_rx_data <= word;
    if (i < 32) sent.push_back(word);
    @(negedge clk_hmc);
    if (i > 0) compare_value("rx_routing", gather_lanes(sent.pop_front()), link_rx_data);
  end
endtask

task automatic walk_bit_slip();
  for (int i = 0; i <= num_lanes; i++) begin
    @(posedge clk_hmc);
    link_bit_slip <= (i < num_lanes) ? (8'b1 << i) : 8'b0;
    @(negedge clk_hmc);
    if (i > 0) compare_value("bit_slip", 8'b1 << site_map[i-1], gt_rx_slide);
  end
  @(negedge clk_hmc);
  compare_value("bit_slip_idle", 0, gt_rx_slide);
endtask

task automatic sweep_status();
  gt_status_t     gs;
  logic [3:0]     flags;
  bridge_status_t exp_status;
  for (int s = 0; s < 32; s++) begin
    for (int f = 0; f < 16; f++) begin
      gs    = s[4:0];
      flags = f[3:0];
      @(posedge clk_hmc);
      gt_status <= gs;
      {hmc_iic_init_done, phy_init_cont_set, tx_phy_reset, rx_phy_reset} <= flags;
      @(negedge clk_hmc);
      exp_status.qpll_lock         = gs.qpll_lock0 & gs.qpll_lock1;
      exp_status.tx_phy_reset_done = gs.phy_tx_ready;
      exp_status.rx_phy_reset_done = gs.phy_rx_ready;
      exp_status.link_rx_ready     = gs.phy_rx_ready & flags[2] & flags[3];
      exp_status.hmc_reset         = 1'b0;   // Released earlier and frozen since
      compare_value("status", exp_status, status);
      compare_value("tx_soft_reset", flags[1], gt_tx_soft_reset);
      compare_value("rx_soft_reset", flags[0], gt_rx_soft_reset);
    end
  end
endtask

`endif

/* test/tb_hmc_phy_bridge.sv */
`timescale 1ns/1ps

module tb_hmc_phy_bridge
  import hmc_lane_pkg::*;
#(
  parameter int link_site = 2   // Mezzanine site handed to the DUT
);

  // --------------------
  // Limits and map
  // --------------------

  localparam int watchdog_cycles = 2 * ((1 << reset_count_log2) + 3000);
  localparam int lock_limit      = (1 << reset_count_log2) + 100;  // Give up on release here

  // Expected wiring for the selected site
  localparam lane_map_t site_map = (link_site == 3) ? lane_map_site3 : lane_map_site2;

  logic                 clk_hmc = 1'b0;
  logic                 SOFT_RESET_IN;
  link_word_t           link_tx_data;
  link_word_t           gt_tx_data;
  link_word_t           gt_rx_data;
  link_word_t           link_rx_data;
  logic [num_lanes-1:0] link_bit_slip;
  logic [num_lanes-1:0] gt_rx_slide;
  gt_status_t           gt_status;
  logic                 hmc_iic_init_done;
  logic                 phy_init_cont_set;
  logic                 tx_phy_reset;
  logic                 rx_phy_reset;
  logic                 gt_tx_soft_reset;
  logic                 gt_rx_soft_reset;
  logic                 hmc_res_n;
  bridge_status_t       status;

  int          errors    = 0;
  int          checks    = 0;
  logic [31:0] lcg_state = 32'h5b09;   // Random stream seed

  always #10 clk_hmc = ~clk_hmc;   // 20 ns period

  hmc_phy_bridge #(
    .link_site (link_site)
  ) uut (
    .clk_hmc           (clk_hmc),
    .SOFT_RESET_IN     (SOFT_RESET_IN),
    .link_tx_data      (link_tx_data),
    .gt_tx_data        (gt_tx_data),
    .gt_rx_data        (gt_rx_data),
    .link_rx_data      (link_rx_data),
    .link_bit_slip     (link_bit_slip),
    .gt_rx_slide       (gt_rx_slide),
    .gt_status         (gt_status),
    .hmc_iic_init_done (hmc_iic_init_done),
    .phy_init_cont_set (phy_init_cont_set),
    .tx_phy_reset      (tx_phy_reset),
    .rx_phy_reset      (rx_phy_reset),
    .gt_tx_soft_reset  (gt_tx_soft_reset),
    .gt_rx_soft_reset  (gt_rx_soft_reset),
    .hmc_res_n         (hmc_res_n),
    .status            (status)
  );

  `include "tb_checks.svh"

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    SOFT_RESET_IN     = 1'b1;
    link_tx_data      = '1;   // Busy inputs, outputs must still idle in reset
    gt_rx_data        = '1;
    link_bit_slip     = '1;
    gt_status         = '0;   // Clock manager not locked yet
    hmc_iic_init_done = 1'b0;
    phy_init_cont_set = 1'b0;
    tx_phy_reset      = 1'b0;
    rx_phy_reset      = 1'b0;

    check_reset_release();
    route_tx_stream();
    route_rx_stream();
    walk_bit_slip();
    sweep_status();

    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Bound on the whole run, reset release dominates
  initial begin
    repeat (watchdog_cycles) @(posedge clk_hmc);
    $display("error: watchdog expired after %0d cycles, tests did not finish",
             watchdog_cycles);
    $display("errors: %0d in %0d checks", errors, checks);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* source/hmc_phy_bridge.sv */
`timescale 1ns/1ps

// Bridge between the HMC link controller and eight transceiver lanes
// on one SKARAB mezzanine site. Lanes are reordered to match the site
// wiring, and reset and status flags are formed for both sides.
module hmc_phy_bridge
  import hmc_lane_pkg::*;
#(
  parameter int link_site = 2   // Mezzanine site, 2 or 3
) (
  input  logic                 clk_hmc,
  input  logic                 SOFT_RESET_IN,

  // Data toward the transceivers
  input  link_word_t           link_tx_data,    // Link lane order
  output link_word_t           gt_tx_data,      // Channel order

  // Data back from the transceivers
  input  link_word_t           gt_rx_data,      // Channel order
  output link_word_t           link_rx_data,    // Link lane order

  // Bit-slip strobes for word alignment
  input  logic [num_lanes-1:0] link_bit_slip,   // One per link lane
  output logic [num_lanes-1:0] gt_rx_slide,     // One per channel

  // Reset and status
  input  gt_status_t           gt_status,
  input  logic                 hmc_iic_init_done, // HMC configured over I2C
  input  logic                 phy_init_cont_set, // Controller init continue
  input  logic                 tx_phy_reset,
  input  logic                 rx_phy_reset,
  output logic                 gt_tx_soft_reset,
  output logic                 gt_rx_soft_reset,
  output logic                 hmc_res_n,         // Controller reset, active low
  output bridge_status_t       status
);

  logic hmc_reset;   // From the lock counter

  // --------------------
  // Lane routing
  // --------------------

  // Site 3 is selected explicitly, anything else uses the site 2 wiring

  // Transmit words, link lane i goes to channel map[i]
  lane_permute #(
    .lane_t   (lane_word_t),
    .lane_map ((link_site == 3) ? lane_map_site3 : lane_map_site2),
    .to_phy   (1'b1)
  ) tx_route (
    .clk_hmc       (clk_hmc),
    .SOFT_RESET_IN (SOFT_RESET_IN),
    .lanes_in      (link_tx_data),
    .lanes_out     (gt_tx_data)
  );

  // Receive words, channel map[i] returns to link lane i
  lane_permute #(
    .lane_t   (lane_word_t),
    .lane_map ((link_site == 3) ? lane_map_site3 : lane_map_site2),
    .to_phy   (1'b0)
  ) rx_route (
    .clk_hmc       (clk_hmc),
    .SOFT_RESET_IN (SOFT_RESET_IN),
    .lanes_in      (gt_rx_data),
    .lanes_out     (link_rx_data)
  );

  // Bit-slip follows the receive lane it aligns
  lane_permute #(
    .lane_t   (logic),       // Single strobe per lane
    .lane_map ((link_site == 3) ? lane_map_site3 : lane_map_site2),
    .to_phy   (1'b1)
  ) slip_route (
    .clk_hmc       (clk_hmc),
    .SOFT_RESET_IN (SOFT_RESET_IN),
    .lanes_in      (link_bit_slip),
    .lanes_out     (gt_rx_slide)
  );

  // --------------------
  // Controller reset
  // --------------------

  link_reset_seq reset_seq (
    .clk_hmc       (clk_hmc),
    .SOFT_RESET_IN (SOFT_RESET_IN),
    .mmcm_locked   (gt_status.mmcm_locked),
    .hmc_reset     (hmc_reset)
  );

  assign hmc_res_n = ~hmc_reset;

  // PHY resets follow the soft reset as well as their own requests
  assign gt_tx_soft_reset = SOFT_RESET_IN | tx_phy_reset;
  assign gt_rx_soft_reset = SOFT_RESET_IN | rx_phy_reset;

  // --------------------
  // Status
  // --------------------

  assign status.qpll_lock         = gt_status.qpll_lock0 & gt_status.qpll_lock1;
  assign status.tx_phy_reset_done = gt_status.phy_tx_ready;
  assign status.rx_phy_reset_done = gt_status.phy_rx_ready;
  // Link RX waits for both init sequences, not just the PHY
  assign status.link_rx_ready     = gt_status.phy_rx_ready & phy_init_cont_set
                                    & hmc_iic_init_done;
  assign status.hmc_reset         = hmc_reset;

endmodule

/* source/link_reset_seq.sv */
`timescale 1ns/1ps

// Holds the link controller in reset until the fabric clock
// manager has been locked for 2^reset_count_log2 cycles.
// Losing lock only pauses the count, it does not restart it.
module link_reset_seq
  import hmc_lane_pkg::*;
(
  input  logic clk_hmc,
  input  logic SOFT_RESET_IN,
  input  logic mmcm_locked,   // From the transceiver wrapper
  output logic hmc_reset      // High keeps the controller in reset
);

  // --------------------
  // Lock counter
  // --------------------

  logic [reset_count_log2:0] rst_cnt;   // Top bit is the done flag
  logic                      rst_done;  // Lock interval complete

  assign rst_done = rst_cnt[reset_count_log2];

  // Counts locked cycles only, freezes once done sets
  always_ff @(posedge clk_hmc or posedge SOFT_RESET_IN) begin
    if (SOFT_RESET_IN) begin
      rst_cnt <= '0;
    end else if (mmcm_locked && !rst_done) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  // --------------------
  // Reset output
  // --------------------

  // Straight from the flop, no extra stage
  assign hmc_reset = ~rst_done;   // Stays low until the next soft reset

endmodule

/* source/lane_permute.sv */
`timescale 1ns/1ps

// One registered stage that reorders whole lanes.
// to_phy = 1 scatters link lane i onto channel lane_map[i],
// to_phy = 0 gathers channel lane_map[i] back into link lane i.
// The map must be a permutation, so every output lane has one source.
module lane_permute
  import hmc_lane_pkg::*;
#(
  parameter type       lane_t   = lane_word_t,     // Payload of one lane
  parameter lane_map_t lane_map = lane_map_site2,  // Link lane to channel map
  parameter bit        to_phy   = 1'b1             // Direction of the reorder
) (
  input  logic                  clk_hmc,
  input  logic                  SOFT_RESET_IN,
  input  lane_t [num_lanes-1:0] lanes_in,   // Indexed by source order
  output lane_t [num_lanes-1:0] lanes_out   // Indexed by destination order
);

  // --------------------
  // Lane crossbar
  // --------------------

  lane_t [num_lanes-1:0] lanes_routed;  // Reordered word, before the register

  // Map is a parameter, so this folds down to plain wiring
  always_comb begin
    lanes_routed = '0;  // Only reached by a map that is not a permutation
    for (int i = 0; i < num_lanes; i++) begin
      if (to_phy) begin
        // Scatter toward the transceivers
        lanes_routed[lane_map[i]] = lanes_in[i];
      end else begin
        // Gather back into link order
        lanes_routed[i] = lanes_in[lane_map[i]];
      end
    end
  end

  // --------------------
  // Output register
  // --------------------

  // One cycle latency, new word accepted every cycle
  always_ff @(posedge clk_hmc or posedge SOFT_RESET_IN) begin
    if (SOFT_RESET_IN) begin
      lanes_out <= '0;          // Idle lanes while in soft reset
    end else begin
      lanes_out <= lanes_routed;
    end
  end

endmodule

/* source/hmc_lane_pkg.sv */
package hmc_lane_pkg;

  // --------------------
  // Lane geometry
  // --------------------

  // Half-width HMC link, eight serial lanes
  localparam int num_lanes  = 8;
  localparam int lane_width = 64;                     // Fabric word per transceiver
  localparam int link_width = num_lanes * lane_width; // Full link word, 512 bits

  typedef logic [lane_width-1:0] lane_word_t;         // One lane worth of data
  typedef lane_word_t [num_lanes-1:0] link_word_t;    // Lane 0 sits in bits 63:0

  // Transceiver channel number, 0 to 7
  typedef logic [$clog2(num_lanes)-1:0] lane_idx_t;

  // Entry i names the channel that carries link lane i
  typedef lane_idx_t [num_lanes-1:0] lane_map_t;

  // --------------------
  // Mezzanine site maps
  // --------------------

  // Site 2, lanes land on PHY21 and PHY22 quads
  localparam lane_map_t lane_map_site2 = '{
    0: 3'd7,   // PHY22 lane 3
    1: 3'd4,   // PHY22 lane 0
    2: 3'd3,   // PHY21 lane 3
    3: 3'd0,   // PHY21 lane 0
    4: 3'd6,   // PHY22 lane 2
    5: 3'd5,   // PHY22 lane 1
    6: 3'd2,   // PHY21 lane 2
    7: 3'd1    // PHY21 lane 1
  };

  // Site 3, lanes land on PHY11 and PHY12 quads
  localparam lane_map_t lane_map_site3 = '{
    0: 3'd0,   // PHY11 lane 3
    1: 3'd3,   // PHY11 lane 0
    2: 3'd4,   // PHY12 lane 3
    3: 3'd7,   // PHY12 lane 0
    4: 3'd1,   // PHY11 lane 2
    5: 3'd2,   // PHY11 lane 1
    6: 3'd5,   // PHY12 lane 2
    7: 3'd6    // PHY12 lane 1
  };

  // --------------------
  // Reset sequencing
  // --------------------

  // Controller leaves reset once this counter bit sets, 2^17 locked cycles
  localparam int reset_count_log2 = 17;

  // --------------------
  // Status groups
  // --------------------

  // Flags reported by the transceiver wrapper
  typedef struct packed {
    logic mmcm_locked;   // Fabric clock manager locked
    logic qpll_lock0;    // Quad PLL, first quad
    logic qpll_lock1;    // Quad PLL, second quad
    logic phy_tx_ready;  // TX reset sequence finished
    logic phy_rx_ready;  // RX reset sequence finished
  } gt_status_t;

  // Flags the bridge hands upward
  typedef struct packed {
    logic qpll_lock;          // Both quad PLLs locked
    logic tx_phy_reset_done;
    logic rx_phy_reset_done;
    logic link_rx_ready;      // RX ready and init sequence complete
    logic hmc_reset;          // Controller held in reset
  } bridge_status_t;

endpackage
